// ==== common/dbus_pkg.sv ====
/*
 * Shared definitions for the data-bus user stage: bus sizes, vector types,
 * the per-lane channel struct, register map and meta record constants.
 */

package dbus_pkg;

   // --------------------
   // Bus geometry
   // --------------------
   localparam int NUM_CHANNELS   = 3;
   localparam int WORDS_PER_LANE = 8;
   localparam int WORD_W         = 16;
   localparam int DATA_W         = WORDS_PER_LANE * WORD_W;

   // Sideband widths
   localparam int REC_NUM_W = 16;
   localparam int TS_W      = 48;
   localparam int USER_ID_W = 2;

   // Register interface widths
   localparam int CFG_ADDR_W = 2;
   localparam int CFG_DATA_W = 32;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [DATA_W-1:0]     lane_data_t;
   typedef logic [REC_NUM_W-1:0]  rec_num_t;
   typedef logic [TS_W-1:0]       timestamp_t;
   typedef logic [USER_ID_W-1:0]  user_id_t;
   typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
   typedef logic [CFG_DATA_W-1:0] cfg_data_t;

   // One bus lane; user_id is don't-care on the input side
   typedef struct packed {
      logic       valid;
      logic       record_start;
      logic       record_stop;
      rec_num_t   record_number;
      timestamp_t timestamp;
      user_id_t   user_id;
      lane_data_t data;
   } chan_t;

   // Lane 0 sits at the low end of the bus word
   typedef chan_t [NUM_CHANNELS-1:0] bus_t;

   // --------------------
   // Register map
   // --------------------
   localparam cfg_addr_t ADDR_ID      = 2'd0;
   localparam cfg_addr_t ADDR_CTRL    = 2'd1;
   localparam cfg_addr_t ADDR_BASE    = 2'd2;
   localparam cfg_addr_t ADDR_SCRATCH = 2'd3;

   localparam cfg_data_t ID_VALUE = 32'h1234_5678;

   // Test pattern select in CTRL
   localparam int CTRL_PATTERN_BIT = 31;

   // --------------------
   // Meta record
   // --------------------
   localparam int META_CH = 2;

   // Marker words 0..5, word 0 in the low bits
   localparam word_t [5:0] META_MARKERS = {
      16'hFFFF,
      16'hEEEE,
      16'hDDDD,
      16'hCCCC,
      16'hBBBB,
      16'hAAAA
   };

   // Word 7 of the meta record
   localparam word_t META_TRAILER = 16'hABCD;

endpackage

// ==== logic/cfg_regs.sv ====
/*
 * Configuration register file: ID, control, pattern base and scratch.
 * Strobed writes, combinational read port.
 */
`timescale 1ns/1ps

module cfg_regs (
   input  logic                data_clk_i,
   input  logic                data_rst_i,
   input  logic                cfg_we_i,
   input  dbus_pkg::cfg_addr_t cfg_addr_i,
   input  dbus_pkg::cfg_data_t cfg_wdata_i,
   input  dbus_pkg::cfg_addr_t cfg_raddr_i,
   output dbus_pkg::cfg_data_t cfg_rdata_o,
   output logic                pattern_en_o,
   output dbus_pkg::word_t     pattern_base_o
);

   dbus_pkg::cfg_data_t ctrl_q;
   dbus_pkg::cfg_data_t base_q;
   dbus_pkg::cfg_data_t scratch_q;

   // --------------------
   // Write side
   // --------------------
   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         ctrl_q    <= '0;
         base_q    <= '0;
         scratch_q <= '0;
      end else if (cfg_we_i) begin
         case (cfg_addr_i)
            dbus_pkg::ADDR_CTRL:    ctrl_q    <= cfg_wdata_i;
            dbus_pkg::ADDR_BASE:    base_q    <= cfg_wdata_i;
            dbus_pkg::ADDR_SCRATCH: scratch_q <= cfg_wdata_i;
            // ID is read only
            default: begin
            end
         endcase
      end
   end

   // --------------------
   // Read side
   // --------------------
   always_comb begin
      case (cfg_raddr_i)
         dbus_pkg::ADDR_ID:      cfg_rdata_o = dbus_pkg::ID_VALUE;
         dbus_pkg::ADDR_CTRL:    cfg_rdata_o = ctrl_q;
         dbus_pkg::ADDR_BASE:    cfg_rdata_o = base_q;
         dbus_pkg::ADDR_SCRATCH: cfg_rdata_o = scratch_q;
         default:                cfg_rdata_o = '0;
      endcase
   end

   // Control fields to the datapath
   assign pattern_en_o   = ctrl_q[dbus_pkg::CTRL_PATTERN_BIT];

   // Pattern words are 16 bits, upper half of BASE unused
   assign pattern_base_o = base_q[dbus_pkg::WORD_W-1:0];

endmodule

// ==== datapath/pattern_gen.sv ====
/*
 * Test pattern source: a registered ramp of base + k in sample word k.
 */
`timescale 1ns/1ps

module pattern_gen (
   input  logic                 data_clk_i,
   input  logic                 data_rst_i,
   input  dbus_pkg::word_t      pattern_base_i,
   output dbus_pkg::lane_data_t pattern_data_o
);

   dbus_pkg::lane_data_t pattern_q;

   // Word 0 in the low bits, each word wraps at 16 bits
   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         pattern_q <= '0;
      end else begin
         for (int k = 0; k < dbus_pkg::WORDS_PER_LANE; k++) begin
            pattern_q[k*dbus_pkg::WORD_W +: dbus_pkg::WORD_W] <=
               pattern_base_i + dbus_pkg::word_t'(k);
         end
      end
   end

   // Shared by lanes 0 and 1
   assign pattern_data_o = pattern_q;

endmodule

// ==== datapath/bus_router.sv ====
/*
 * Bus router: registers the incoming bus word, substitutes test pattern
 * data on lanes 0 and 1, inserts the meta lane and tags user IDs.
 */
`timescale 1ns/1ps

module bus_router (
   input  logic                 data_clk_i,
   input  logic                 data_rst_i,
   input  dbus_pkg::bus_t       bus_i,
   input  logic                 pattern_en_i,
   input  dbus_pkg::lane_data_t pattern_data_i,
   input  dbus_pkg::chan_t      meta_lane_i,
   output dbus_pkg::chan_t      ch0_q_o,
   output dbus_pkg::bus_t       bus_o
);

   dbus_pkg::bus_t bus_q;

   // --------------------
   // Input register
   // --------------------
   // All lanes are captured; the one at META_CH is replaced further down
   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         bus_q <= '0;
      end else begin
         bus_q <= bus_i;
      end
   end

   // Registered lane 0 drives the meta record logic
   assign ch0_q_o = bus_q[0];

   // --------------------
   // Output assembly
   // --------------------
   always_comb begin
      bus_o = bus_q;
      for (int ch = 0; ch < dbus_pkg::NUM_CHANNELS; ch++) begin
         if (ch == dbus_pkg::META_CH) begin
            bus_o[ch] = meta_lane_i;
         end else if (pattern_en_i) begin
            // Sideband still passes through, only samples change
            bus_o[ch].data = pattern_data_i;
         end
         // Every lane carries its own index as user ID
         bus_o[ch].user_id = dbus_pkg::user_id_t'(ch);
      end
   end

endmodule

// ==== datapath/meta_packet.sv ====
/*
 * Channel 2 meta record: one-sample record emitted the cycle after a
 * channel 0 record start, carrying markers and a free-running count.
 */
`timescale 1ns/1ps

module meta_packet (
   input  logic            data_clk_i,
   input  logic            data_rst_i,
   input  dbus_pkg::chan_t ch0_q_i,
   output dbus_pkg::chan_t meta_lane_o
);

   dbus_pkg::word_t cnt_q;
   logic            emit_q;

   // --------------------
   // Cycle counter
   // --------------------
   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // --------------------
   // Emit strobe
   // --------------------
   // Follows lane 0 start by one cycle
   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         emit_q <= 1'b0;
      end else begin
         emit_q <= ch0_q_i.record_start;
      end
   end

   // --------------------
   // Record assembly
   // --------------------
   always_comb begin
      meta_lane_o = '0;

      // Single-sample record, start and stop in the same beat
      meta_lane_o.valid        = emit_q;
      meta_lane_o.record_start = emit_q;
      meta_lane_o.record_stop  = emit_q;

      // Correlate with what lane 0 shows in the emit cycle
      meta_lane_o.record_number = ch0_q_i.record_number;
      meta_lane_o.timestamp     = ch0_q_i.timestamp;
      meta_lane_o.user_id       = dbus_pkg::user_id_t'(dbus_pkg::META_CH);

      // Words 0..5 markers, word 6 count, word 7 trailer
      meta_lane_o.data = {dbus_pkg::META_TRAILER, cnt_q, dbus_pkg::META_MARKERS};
   end

endmodule

// ==== logic/dbus_user_top.sv ====
/*
 * Top level of the data-bus user stage: configuration registers,
 * pattern generator, bus router and meta record source.
 */
`timescale 1ns/1ps

module dbus_user_top (
   input  logic                data_clk_i,
   input  logic                data_rst_i,
   input  dbus_pkg::bus_t      bus_i,
   output dbus_pkg::bus_t      bus_o,
   input  logic                cfg_we_i,
   input  dbus_pkg::cfg_addr_t cfg_addr_i,
   input  dbus_pkg::cfg_data_t cfg_wdata_i,
   input  dbus_pkg::cfg_addr_t cfg_raddr_i,
   output dbus_pkg::cfg_data_t cfg_rdata_o
);

   logic                 pattern_en;
   dbus_pkg::word_t      pattern_base;
   dbus_pkg::lane_data_t pattern_data;
   dbus_pkg::chan_t      ch0_q;
   dbus_pkg::chan_t      meta_lane;

   cfg_regs u_cfg_regs (
      .data_clk_i     (data_clk_i),
      .data_rst_i     (data_rst_i),
      .cfg_we_i       (cfg_we_i),
      .cfg_addr_i     (cfg_addr_i),
      .cfg_wdata_i    (cfg_wdata_i),
      .cfg_raddr_i    (cfg_raddr_i),
      .cfg_rdata_o    (cfg_rdata_o),
      .pattern_en_o   (pattern_en),
      .pattern_base_o (pattern_base)
   );

   pattern_gen u_pattern_gen (
      .data_clk_i     (data_clk_i),
      .data_rst_i     (data_rst_i),
      .pattern_base_i (pattern_base),
      .pattern_data_o (pattern_data)
   );

   // Input register and lane assembly
   bus_router u_bus_router (
      .data_clk_i     (data_clk_i),
      .data_rst_i     (data_rst_i),
      .bus_i          (bus_i),
      .pattern_en_i   (pattern_en),
      .pattern_data_i (pattern_data),
      .meta_lane_i    (meta_lane),
      .ch0_q_o        (ch0_q),
      .bus_o          (bus_o)
   );

   // Channel 2 replacement record
   meta_packet u_meta_packet (
      .data_clk_i  (data_clk_i),
      .data_rst_i  (data_rst_i),
      .ch0_q_i     (ch0_q),
      .meta_lane_o (meta_lane)
   );

endmodule

// ==== bench/dbus_user_asserts.sv ====
/*
 * Concurrent checks on the top-level bus output: meta lane shape,
 * meta timing against lane 0 and user ID tagging.
 */
`timescale 1ns/1ps

module dbus_user_asserts (
   input logic           data_clk_i,
   input logic           data_rst_i,
   input dbus_pkg::bus_t out_bus_i
);

   logic l0_start;
   logic l2_valid;
   logic l2_start;
   logic l2_stop;

   // Count of failed assertions
   int fail_count = 0;

   assign l0_start = out_bus_i[0].record_start;
   assign l2_valid = out_bus_i[2].valid;
   assign l2_start = out_bus_i[2].record_start;
   assign l2_stop  = out_bus_i[2].record_stop;

   // Meta record is a single sample
   a_meta_single : assert property (@(posedge data_clk_i) disable iff (data_rst_i)
      l2_valid |-> (l2_start && l2_stop))
      else begin
         fail_count++;
         $error("Meta lane valid without start and stop");
      end

   // Meta record follows a lane 0 start by one cycle
   a_meta_follow : assert property (@(posedge data_clk_i) disable iff (data_rst_i)
      l2_valid == $past(l0_start))
      else begin
         fail_count++;
         $error("Meta lane valid does not follow lane 0 start");
      end

   a_user_id : assert property (@(posedge data_clk_i) disable iff (data_rst_i)
      (out_bus_i[0].user_id == 2'd0) && (out_bus_i[1].user_id == 2'd1) &&
      (out_bus_i[2].user_id == 2'd2))
      else begin
         fail_count++;
         $error("Output user_id fields are not the lane indices");
      end

endmodule

bind dbus_user_top dbus_user_asserts u_asserts (
   .data_clk_i (data_clk_i),
   .data_rst_i (data_rst_i),
   .out_bus_i  (bus_o)
);

// ==== bench/tb_dbus_user.sv ====
/*
 * Testbench for the data-bus user stage: step table with bus words and
 * register actions, one-cycle reference model, checks and watchdog.
 */
`timescale 1ns/1ps

module tb_dbus_user;

   localparam int CLK_PERIOD    = 100;
   localparam int RESET_CYCLES  = 5;
   localparam int NUM_STEPS     = 24;
   localparam int MARGIN_CYCLES = 20;

   logic                data_clk;
   logic                data_rst;
   dbus_pkg::bus_t      bus_in;
   dbus_pkg::bus_t      bus_out;
   logic                cfg_we;
   dbus_pkg::cfg_addr_t cfg_addr;
   dbus_pkg::cfg_data_t cfg_wdata;
   dbus_pkg::cfg_addr_t cfg_raddr;
   dbus_pkg::cfg_data_t cfg_rdata;

   // Step table
   dbus_pkg::bus_t      step_bus   [NUM_STEPS];
   logic                step_we    [NUM_STEPS];
   dbus_pkg::cfg_addr_t step_waddr [NUM_STEPS];
   dbus_pkg::cfg_data_t step_wdata [NUM_STEPS];
   dbus_pkg::cfg_addr_t step_raddr [NUM_STEPS];

   integer seed;
   int     error_count;
   int     check_count;

   // Reference model state
   dbus_pkg::cfg_data_t  m_ctrl;
   dbus_pkg::cfg_data_t  m_base;
   dbus_pkg::cfg_data_t  m_scratch;
   dbus_pkg::bus_t       exp_q;
   logic                 exp_emit;
   dbus_pkg::lane_data_t exp_pat;
   logic                 have_meta;
   dbus_pkg::word_t      last_cnt;
   int                   last_step;
   int                   meta_count;

   dbus_user_top dut (
      .data_clk_i  (data_clk),
      .data_rst_i  (data_rst),
      .bus_i       (bus_in),
      .bus_o       (bus_out),
      .cfg_we_i    (cfg_we),
      .cfg_addr_i  (cfg_addr),
      .cfg_wdata_i (cfg_wdata),
      .cfg_raddr_i (cfg_raddr),
      .cfg_rdata_o (cfg_rdata)
   );

   initial begin
      data_clk = 1'b0;
      forever #(CLK_PERIOD / 2) data_clk = ~data_clk;
   end

   task automatic compare_val(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // Word k holds base + k, wrapping at 16 bits
   function automatic dbus_pkg::lane_data_t ramp_data(input dbus_pkg::word_t base);
      dbus_pkg::lane_data_t r;
      for (int k = 0; k < dbus_pkg::WORDS_PER_LANE; k++) begin
         r[k*16 +: 16] = base + 16'(k);
      end
      return r;
   endfunction

   function automatic dbus_pkg::cfg_data_t model_read(input dbus_pkg::cfg_addr_t a);
      case (a)
         dbus_pkg::ADDR_CTRL:    return m_ctrl;
         dbus_pkg::ADDR_BASE:    return m_base;
         dbus_pkg::ADDR_SCRATCH: return m_scratch;
         default:                return 32'h1234_5678;
      endcase
   endfunction

   // --------------------
   // Stimulus table
   // --------------------
   task automatic build_table();
      logic [31:0] rnd;
      logic [31:0] rnd2;
      for (int s = 0; s < NUM_STEPS; s++) begin
         for (int ch = 0; ch < dbus_pkg::NUM_CHANNELS; ch++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            step_bus[s][ch].valid         = rnd[0];
            step_bus[s][ch].record_start  = rnd[1];
            step_bus[s][ch].record_stop   = rnd[2];
            step_bus[s][ch].record_number = rnd[31:16];
            step_bus[s][ch].timestamp     = {rnd[15:0], rnd2};
            step_bus[s][ch].user_id       = rnd[4:3];
            step_bus[s][ch].data = {$random(seed), $random(seed),
                                    $random(seed), $random(seed)};
         end
         // Lane 0 starts only where meta records are wanted
         step_bus[s][0].record_start = (s == 5) || (s == 8) || (s == 13) || (s == 17);
         if (step_bus[s][0].record_start) begin
            step_bus[s][0].valid = 1'b1;
         end
         step_we[s]    = 1'b0;
         step_waddr[s] = dbus_pkg::ADDR_ID;
         step_wdata[s] = '0;
         step_raddr[s] = dbus_pkg::ADDR_ID;
      end

      // Register writes with read-backs one step later
      step_we[0]    = 1'b1;
      step_waddr[0] = dbus_pkg::ADDR_SCRATCH;
      step_wdata[0] = $random(seed);
      step_we[1]    = 1'b1;
      step_waddr[1] = dbus_pkg::ADDR_BASE;
      step_wdata[1] = $random(seed);
      step_raddr[1] = dbus_pkg::ADDR_SCRATCH;
      step_we[2]    = 1'b1;
      step_waddr[2] = dbus_pkg::ADDR_ID;
      step_wdata[2] = $random(seed);
      step_raddr[2] = dbus_pkg::ADDR_BASE;
      step_raddr[3] = dbus_pkg::ADDR_ID;

      // Pattern on from step 10 onwards
      rnd = $random(seed);
      step_we[10]    = 1'b1;
      step_waddr[10] = dbus_pkg::ADDR_CTRL;
      step_wdata[10] = {1'b1, rnd[30:0]};
      step_raddr[11] = dbus_pkg::ADDR_CTRL;

      // New BASE while the pattern is on
      step_we[14]    = 1'b1;
      step_waddr[14] = dbus_pkg::ADDR_BASE;
      step_wdata[14] = $random(seed);
      step_raddr[15] = dbus_pkg::ADDR_BASE;
   endtask

   task automatic inspect_reset_state();
      for (int ch = 0; ch < dbus_pkg::NUM_CHANNELS; ch++) begin
         compare_val($sformatf("lane%0d valid", ch), bus_out[ch].valid, 1'b0);
         compare_val($sformatf("lane%0d record_start", ch), bus_out[ch].record_start, 1'b0);
         compare_val($sformatf("lane%0d record_stop", ch), bus_out[ch].record_stop, 1'b0);
      end
      compare_val("cfg_rdata_o", cfg_rdata, 32'h1234_5678);
   endtask

   // --------------------
   // Reference model
   // --------------------
   // Step i-1 was sampled at the edge just before this check
   task automatic advance_model(input int i);
      logic            old_start;
      dbus_pkg::word_t old_base;
      old_start = exp_q[0].record_start;
      old_base  = m_base[15:0];
      if (i > 0) begin
         exp_q = step_bus[i-1];
         if (step_we[i-1]) begin
            case (step_waddr[i-1])
               dbus_pkg::ADDR_CTRL:    m_ctrl    = step_wdata[i-1];
               dbus_pkg::ADDR_BASE:    m_base    = step_wdata[i-1];
               dbus_pkg::ADDR_SCRATCH: m_scratch = step_wdata[i-1];
               default: begin
               end
            endcase
         end
      end
      exp_emit = old_start;
      // Pattern register lags the BASE register by one cycle
      exp_pat  = ramp_data(old_base);
   endtask

   task automatic score_outputs(input int i);
      dbus_pkg::lane_data_t exp_data;
      dbus_pkg::word_t      cnt;
      for (int ch = 0; ch < 2; ch++) begin
         exp_data = m_ctrl[dbus_pkg::CTRL_PATTERN_BIT] ? exp_pat : exp_q[ch].data;
         compare_val($sformatf("lane%0d valid", ch), bus_out[ch].valid, exp_q[ch].valid);
         compare_val($sformatf("lane%0d record_start", ch), bus_out[ch].record_start,
                     exp_q[ch].record_start);
         compare_val($sformatf("lane%0d record_stop", ch), bus_out[ch].record_stop,
                     exp_q[ch].record_stop);
         compare_val($sformatf("lane%0d record_number", ch), bus_out[ch].record_number,
                     exp_q[ch].record_number);
         compare_val($sformatf("lane%0d timestamp", ch), bus_out[ch].timestamp,
                     exp_q[ch].timestamp);
         compare_val($sformatf("lane%0d user_id", ch), bus_out[ch].user_id, ch);
         compare_val($sformatf("lane%0d data", ch), bus_out[ch].data, exp_data);
      end

      compare_val("lane2 valid", bus_out[2].valid, exp_emit);
      compare_val("lane2 record_start", bus_out[2].record_start, exp_emit);
      compare_val("lane2 record_stop", bus_out[2].record_stop, exp_emit);
      compare_val("lane2 user_id", bus_out[2].user_id, 2);
      if (exp_emit) begin
         compare_val("lane2 record_number", bus_out[2].record_number,
                     exp_q[0].record_number);
         compare_val("lane2 timestamp", bus_out[2].timestamp, exp_q[0].timestamp);
         for (int k = 0; k < 6; k++) begin
            compare_val($sformatf("lane2 marker word %0d", k), bus_out[2].data[k*16 +: 16],
                        16'hAAAA + 16'(k) * 16'h1111);
         end
         compare_val("lane2 trailer word", bus_out[2].data[112 +: 16], 16'hABCD);
         // Counter advances once per cycle between records
         cnt = bus_out[2].data[96 +: 16];
         if (have_meta) begin
            compare_val("lane2 count delta", 16'(cnt - last_cnt), 16'(i - last_step));
         end
         have_meta  = 1'b1;
         last_cnt   = cnt;
         last_step  = i;
         meta_count++;
      end

      compare_val("cfg_rdata_o", cfg_rdata, model_read(step_raddr[i]));
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      seed        = 13;
      error_count = 0;
      check_count = 0;
      data_rst    = 1'b1;
      bus_in      = '0;
      cfg_we      = 1'b0;
      cfg_addr    = dbus_pkg::ADDR_ID;
      cfg_wdata   = '0;
      cfg_raddr   = dbus_pkg::ADDR_ID;
      m_ctrl      = '0;
      m_base      = '0;
      m_scratch   = '0;
      exp_q       = '0;
      exp_emit    = 1'b0;
      exp_pat     = '0;
      have_meta   = 1'b0;
      last_cnt    = '0;
      last_step   = 0;
      meta_count  = 0;
      build_table();

      repeat (RESET_CYCLES) @(posedge data_clk);
      data_rst <= 1'b0;
      @(negedge data_clk);
      inspect_reset_state();

      for (int i = 0; i < NUM_STEPS; i++) begin
         @(posedge data_clk);
         bus_in    <= step_bus[i];
         cfg_we    <= step_we[i];
         cfg_addr  <= step_waddr[i];
         cfg_wdata <= step_wdata[i];
         cfg_raddr <= step_raddr[i];
         @(negedge data_clk);
         advance_model(i);
         score_outputs(i);
      end

      if (meta_count < 2) begin
         error_count++;
         $display("Fewer than two meta records were seen on lane 2");
      end
      error_count += dut.u_asserts.fail_count;
      $display("Checks: %0d, assertion failures: %0d, errors: %0d",
               check_count, dut.u_asserts.fail_count, error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // Watchdog sized from reset, table length and a margin
   initial begin
      #((RESET_CYCLES + NUM_STEPS + MARGIN_CYCLES) * CLK_PERIOD);
      $display("Watchdog expired before the step table completed");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== dbus_user.f ====
common/dbus_pkg.sv
logic/cfg_regs.sv
datapath/pattern_gen.sv
datapath/bus_router.sv
datapath/meta_packet.sv
logic/dbus_user_top.sv
bench/dbus_user_asserts.sv
bench/tb_dbus_user.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the data-bus user stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dbus_user \
   -f dbus_user.f \
   --Mdir obj_dir -o sim_dbus_user
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_dbus_user)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
